// File: all.f
wb_pkg.sv
arch_reg_file.sv
wbaq.sv
writeback_stage.sv
writeback_top.sv
tb_writeback.sv

// File: arch_reg_file.sv
`timescale 1ns/1ps

module arch_reg_file #(
    parameter int DATA_W   = 32,
    parameter int NUM_REGS = 8
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  wb_pkg::reg_wr_t             wr,
    input  logic [$clog2(NUM_REGS)-1:0] rd_idx,
    output logic [DATA_W-1:0]           rd_data
);
    localparam int IDX_W = $clog2(NUM_REGS);
    localparam int NS    = wb_pkg::NUM_SLOTS;
    localparam int RIW   = wb_pkg::REG_IDX_W;
    localparam int SDW   = wb_pkg::SLOT_DATA_W;

    logic [DATA_W-1:0] regs [NUM_REGS];

    // per-slot write fields, sliced out of the flat bundle
    logic [IDX_W-1:0]  wr_idx  [NS];
    logic [DATA_W-1:0] wr_data [NS];

    always_comb begin
        for (int s = 0; s < NS; s++) begin
            wr_idx[s]  = wr.idx[s*RIW +: IDX_W];
            wr_data[s] = wr.data[s*SDW +: DATA_W];  // truncated to file width
        end
    end

    // slots applied low to high so the higher slot wins a shared index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int s = 0; s < NS; s++) begin
                if (wr.we[s]) begin
                    regs[wr_idx[s]] <= wr_data[s];
                end
            end
        end
    end

    assign rd_data = regs[rd_idx];  // operand read, no bypass

    // a write lands on the read port one cycle later
    a_write_visible: assert property (@(posedge clk) disable iff (!arst_n)
        wr.we[NS-1] |=> (rd_idx != $past(wr_idx[NS-1]))
                        || (rd_data == $past(wr_data[NS-1])))
        else $error("arch_reg_file: top slot write not visible on read port");

endmodule

// File: run.sh
#!/bin/sh
# build and run the writeback testbench, then scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_writeback -f all.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log
grep -q "TEST FAILED" sim.log && echo "simulation failed, see sim.log" && exit 1
echo "simulation passed"
exit 0

// File: tb_writeback.sv
`timescale 1ns/1ps

module tb_writeback;
    localparam int NS         = wb_pkg::NUM_SLOTS;
    localparam int DEPTH      = 2;
    localparam int MAX_CYCLES = 2000;  // ~60 uops at roughly 10 cycles of drain each, 3x margin

    logic             clk;
    logic             arst_n;
    logic             valid_in;
    logic             interrupt_in;
    logic             mem_ack;
    logic             hold_ack;  // responder holds off while set
    wb_pkg::wb_uop_t  uop;
    wb_pkg::wb_slot_t slots [NS];
    wb_pkg::br_info_t br;
    logic [2:0]       gpr_rd_idx = '0;
    logic [2:0]       seg_rd_idx = '0;
    logic [31:0]      gpr_rd_data;
    logic [15:0]      seg_rd_data;
    wb_pkg::mem_wr_t  mem_wr;
    logic             valid_out;
    logic             stall;
    logic             mem_req;
    logic             resteer;
    logic             final_ie_val;
    logic             halts;
    logic             halt_flop;
    logic [31:0]      new_eip;
    logic [31:0]      new_fip_even;
    logic [31:0]      new_fip_odd;
    logic [3:0]       final_ie_type;
    logic [15:0]      cs_out;
    logic [17:0]      eflags_out;

    // staging for the next micro-op
    wb_pkg::wb_uop_t  nxt_uop;
    wb_pkg::wb_slot_t nxt_slots [NS];
    wb_pkg::br_info_t nxt_br;
    logic             nxt_irq;

    // reference model state
    logic [63:0]     slot_val [NS];
    logic            has_mem;
    int              mem_slot;
    logic            exp_stall;
    logic            accept;
    wb_pkg::mem_wr_t exp_push;
    wb_pkg::mem_wr_t exp_head;
    wb_pkg::mem_wr_t exp_mem [$];
    int              exp_cnt;
    logic            halt_seen;
    logic [31:0]     gpr_model [8];
    logic [15:0]     seg_model [8];
    logic [31:0]     exp_gpr;
    logic [15:0]     exp_seg;
    logic [31:0]     exp_eip;
    logic [31:0]     exp_fip_even;
    logic [31:0]     exp_fip_odd;
    logic [15:0]     exp_cs;
    int              cycles = 0;

    writeback_top #(.WBAQ_DEPTH(DEPTH), .GPR_W(32), .SEG_W(16)) writeback_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERROR: %s = 0x%h, expected 0x%h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        $display("TEST FAILED");
        $fatal(1, "%s", what);
    endtask

    function automatic wb_pkg::mem_size_e size_rule(input wb_pkg::wb_uop_t u);
        for (int b = 0; b < 4; b++) begin
            if (u.size_ovr[b]) begin
                return wb_pkg::mem_size_e'(2'(b));
            end
        end
        if (u.far_xfer) begin
            return wb_pkg::SIZE_QWORD;  // offset plus selector
        end
        return u.op_size;
    endfunction

    always_comb begin
        has_mem  = 1'b0;
        mem_slot = 0;
        for (int i = 0; i < NS; i++) begin
            slot_val[i] = slots[i].data;
        end
        if (uop.far_xfer) begin
            slot_val[0] = {48'h0, slots[0].data[47:32]};  // selector through slot 0
        end
        for (int i = NS - 1; i >= 0; i--) begin
            if (slots[i].wb && slots[i].kind == wb_pkg::DEST_MEM) begin
                has_mem  = 1'b1;
                mem_slot = i;
            end
        end
        exp_stall     = valid_in && has_mem && (exp_cnt == DEPTH);
        accept        = valid_in && !exp_stall;
        exp_push.addr = slots[mem_slot].dest.addr;
        exp_push.data = slot_val[mem_slot];
        exp_push.size = size_rule(uop);
    end

    assign exp_gpr = gpr_model[gpr_rd_idx];
    assign exp_seg = seg_model[seg_rd_idx];
    assign exp_eip = !br.taken ? uop.eip : (uop.far_xfer ? slots[0].data[31:0] : br.fip);
    assign exp_cs  = (accept && uop.far_xfer) ? slots[0].data[47:32] : uop.cs;

    // even line has bit 4 clear, odd line has it set
    assign exp_fip_odd  = {br.fip[31:5], 5'h10};
    assign exp_fip_even = {br.fip[31:5], 5'h00} + (br.fip[4] ? 32'd32 : 32'd0);

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_mem.delete();
            exp_cnt   <= 0;
            exp_head  <= '0;
            halt_seen <= 1'b0;
            for (int r = 0; r < 8; r++) begin
                gpr_model[r] <= '0;
                seg_model[r] <= '0;
            end
        end else begin
            if (mem_req && mem_ack) begin
                void'(exp_mem.pop_front());  // handshake retires the head
            end
            if (accept && has_mem) begin
                exp_mem.push_back(exp_push);
            end
            exp_cnt <= exp_mem.size();
            if (exp_mem.size() != 0) begin
                exp_head <= exp_mem[0];
            end
            if (accept && uop.halt) begin
                halt_seen <= 1'b1;
            end
            for (int i = 0; i < NS; i++) begin  // later slot overrides earlier
                if (accept && slots[i].wb && slots[i].kind == wb_pkg::DEST_REG) begin
                    gpr_model[slots[i].dest.rv.idx] <= slot_val[i][31:0];
                end
                if (accept && slots[i].wb && slots[i].kind == wb_pkg::DEST_SEG) begin
                    seg_model[slots[i].dest.rv.idx] <= slot_val[i][15:0];
                end
            end
        end
    end

    a_stall: assert property (@(posedge clk) disable iff (!arst_n) stall == exp_stall)
        else report_mismatch("stall", 64'($sampled(stall)), 64'($sampled(exp_stall)));
    a_valid: assert property (@(posedge clk) disable iff (!arst_n) valid_out == accept)
        else report_mismatch("valid_out", 64'($sampled(valid_out)), 64'($sampled(accept)));
    a_eip: assert property (@(posedge clk) disable iff (!arst_n) new_eip == exp_eip)
        else report_mismatch("new_eip", 64'($sampled(new_eip)), 64'($sampled(exp_eip)));
    a_fip_even: assert property (@(posedge clk) disable iff (!arst_n)
        new_fip_even == exp_fip_even)
        else report_mismatch("new_fip_even", 64'($sampled(new_fip_even)),
                             64'($sampled(exp_fip_even)));
    a_fip_odd: assert property (@(posedge clk) disable iff (!arst_n)
        new_fip_odd == exp_fip_odd)
        else report_mismatch("new_fip_odd", 64'($sampled(new_fip_odd)),
                             64'($sampled(exp_fip_odd)));
    a_resteer: assert property (@(posedge clk) disable iff (!arst_n)
        resteer == (accept && br.valid && !br.correct))
        else report_mismatch("resteer", 64'($sampled(resteer)),
                             64'($sampled(accept && br.valid && !br.correct)));
    a_ie_val: assert property (@(posedge clk) disable iff (!arst_n)
        final_ie_val == (uop.ie || interrupt_in))
        else report_mismatch("final_ie_val", 64'($sampled(final_ie_val)),
                             64'($sampled(uop.ie || interrupt_in)));
    a_ie_type: assert property (@(posedge clk) disable iff (!arst_n)
        final_ie_type == {interrupt_in, uop.ie_type})
        else report_mismatch("final_ie_type", 64'($sampled(final_ie_type)),
                             64'($sampled({interrupt_in, uop.ie_type})));
    a_halts: assert property (@(posedge clk) disable iff (!arst_n) halts == (accept && uop.halt))
        else report_mismatch("halts", 64'($sampled(halts)), 64'($sampled(accept && uop.halt)));
    a_halt_flop: assert property (@(posedge clk) disable iff (!arst_n) halt_flop == halt_seen)
        else report_mismatch("halt_flop", 64'($sampled(halt_flop)), 64'($sampled(halt_seen)));
    a_cs: assert property (@(posedge clk) disable iff (!arst_n) cs_out == exp_cs)
        else report_mismatch("cs_out", 64'($sampled(cs_out)), 64'($sampled(exp_cs)));
    a_eflags: assert property (@(posedge clk) disable iff (!arst_n) eflags_out == uop.eflags)
        else report_mismatch("eflags_out", 64'($sampled(eflags_out)),
                             64'($sampled(uop.eflags)));
    a_gpr: assert property (@(posedge clk) disable iff (!arst_n) gpr_rd_data == exp_gpr)
        else report_mismatch("gpr_rd_data", 64'($sampled(gpr_rd_data)), 64'($sampled(exp_gpr)));
    a_seg: assert property (@(posedge clk) disable iff (!arst_n) seg_rd_data == exp_seg)
        else report_mismatch("seg_rd_data", 64'($sampled(seg_rd_data)), 64'($sampled(exp_seg)));
    a_req_expected: assert property (@(posedge clk) disable iff (!arst_n) mem_req |-> exp_cnt != 0)
        else report_failure("memory request with no queued write expected");
    a_addr: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> mem_wr.addr == exp_head.addr)
        else report_mismatch("mem_wr.addr", 64'($sampled(mem_wr.addr)), 64'($sampled(exp_head.addr)));
    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> mem_wr.data == exp_head.data)
        else report_mismatch("mem_wr.data", $sampled(mem_wr.data), $sampled(exp_head.data));
    a_size: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> mem_wr.size == exp_head.size)
        else report_mismatch("mem_wr.size", 64'($sampled(mem_wr.size)), 64'($sampled(exp_head.size)));
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n) mem_req && !mem_ack |=> mem_req)
        else report_failure("mem_req dropped before mem_ack");
    a_req_drop: assert property (@(posedge clk) disable iff (!arst_n) mem_req && mem_ack |=> !mem_req)
        else report_failure("mem_req stayed high after mem_ack");
    a_req_rise: assert property (@(posedge clk) disable iff (!arst_n) $rose(mem_req) |-> !mem_ack)
        else report_failure("mem_req rose while mem_ack still high");
    a_wr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |=> !mem_req || $stable(mem_wr))
        else report_failure("mem_wr changed during a request");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            report_failure("run timed out before the stimulus finished");
        end
    end

    // sweep the read ports so every register is looked at
    always @(posedge clk) begin
        gpr_rd_idx <= gpr_rd_idx + 3'd1;
        seg_rd_idx <= seg_rd_idx - 3'd1;
    end

    // memory side of the four-phase handshake
    initial begin : mem_responder
        int unsigned delay;
        mem_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_req && !mem_ack && !hold_ack) begin
                delay = $urandom_range(5, 0);
                repeat (delay) @(posedge clk);
                mem_ack <= 1'b1;
                @(posedge clk);
                while (mem_req) @(posedge clk);
                mem_ack <= 1'b0;
            end
        end
    end

    task automatic fill_random(input bit mem_ok, input bit far);
        int k;
        bit mem_used;
        mem_used = 1'b0;
        for (int i = 0; i < NS; i++) begin
            k = $urandom_range(3, 0);
            if (k == 3 && (!mem_ok || mem_used)) begin
                k = 1;  // at most one memory slot
            end
            mem_used               = mem_used || (k == 3);
            nxt_slots[i].kind      = wb_pkg::dest_kind_e'(2'(k));
            nxt_slots[i].wb        = ($urandom_range(3, 0) != 0);
            nxt_slots[i].data      = {$urandom, $urandom};
            nxt_slots[i].dest.addr = $urandom;  // junk upper bits for reg targets
        end
        nxt_uop.eip      = $urandom;
        nxt_uop.op_size  = wb_pkg::mem_size_e'(2'($urandom_range(3, 0)));
        nxt_uop.size_ovr = ($urandom_range(1, 0) != 0) ? 4'(1 << $urandom_range(3, 0)) : 4'h0;
        nxt_uop.far_xfer = far;
        nxt_uop.halt     = 1'b0;
        nxt_uop.ie       = 1'($urandom);
        nxt_uop.ie_type  = 3'($urandom);
        nxt_uop.cs       = 16'($urandom);
        nxt_uop.eflags   = 18'($urandom);
        nxt_br.valid     = 1'($urandom);
        nxt_br.taken     = 1'($urandom);
        nxt_br.correct   = 1'($urandom);
        nxt_br.fip       = $urandom;
        nxt_irq          = ($urandom_range(7, 0) == 0);
    endtask

    // present a micro-op and hold it until the stage takes it
    task automatic issue();
        @(posedge clk);
        valid_in     <= 1'b1;
        uop          <= nxt_uop;
        br           <= nxt_br;
        interrupt_in <= nxt_irq;
        for (int i = 0; i < NS; i++) begin
            slots[i] <= nxt_slots[i];
        end
        @(negedge clk);
        while (stall) @(negedge clk);
    endtask

    task automatic drain_queue();
        @(posedge clk);
        valid_in <= 1'b0;
        @(negedge clk);
        while (exp_cnt != 0 || mem_req || mem_ack) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h4d82));
        arst_n       = 1'b0;
        valid_in     = 1'b0;
        interrupt_in = 1'b0;
        hold_ack     = 1'b0;
        uop          = '0;
        br           = '0;
        for (int i = 0; i < NS; i++) begin
            slots[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        assert (!mem_req && !halt_flop && !halts && !resteer && !valid_out && !stall)
            else report_failure("outputs active during reset");
        @(posedge clk);
        arst_n <= 1'b1;

        // all four slots on one gpr index, then one seg index
        fill_random(1'b0, 1'b0);
        for (int i = 0; i < NS; i++) begin
            nxt_slots[i].kind      = wb_pkg::DEST_REG;
            nxt_slots[i].wb        = 1'b1;
            nxt_slots[i].dest.addr = 32'h5;
        end
        issue();
        for (int i = 0; i < NS; i++) begin
            nxt_slots[i].kind = wb_pkg::DEST_SEG;
        end
        issue();
        drain_queue();
        repeat (8) @(posedge clk);

        // far jump loading cs index 1
        fill_random(1'b0, 1'b1);
        nxt_slots[0].kind      = wb_pkg::DEST_SEG;
        nxt_slots[0].wb        = 1'b1;
        nxt_slots[0].data      = 64'h0000_0023_0040_1000;
        nxt_slots[0].dest.addr = 32'h1;
        nxt_br.taken           = 1'b1;
        issue();
        fill_random(1'b0, 1'b1);  // far store, no override
        nxt_uop.size_ovr  = 4'h0;
        nxt_slots[0].kind = wb_pkg::DEST_MEM;
        nxt_slots[0].wb   = 1'b1;
        issue();

        for (int n = 0; n < 40; n++) begin
            fill_random(1'b1, ($urandom_range(7, 0) == 0));
            issue();
        end

        // fill the queue with ack held off
        drain_queue();
        hold_ack = 1'b1;
        for (int n = 0; n < DEPTH; n++) begin
            fill_random(1'b0, 1'b0);
            nxt_slots[2].kind = wb_pkg::DEST_MEM;
            nxt_slots[2].wb   = 1'b1;
            issue();
        end
        fill_random(1'b0, 1'b0);  // no memory slot, goes through
        issue();
        fill_random(1'b0, 1'b0);
        nxt_slots[1].kind = wb_pkg::DEST_MEM;
        nxt_slots[1].wb   = 1'b1;
        fork
            issue();
            begin
                repeat (8) @(negedge clk);
                hold_ack = 1'b0;
            end
        join

        fill_random(1'b1, 1'b0);
        nxt_uop.halt = 1'b1;
        issue();
        for (int n = 0; n < 4; n++) begin
            fill_random(1'b1, 1'b0);
            issue();
        end
        drain_queue();
        repeat (8) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: wb_pkg.sv
package wb_pkg;

    localparam int NUM_SLOTS   = 4;  // result slots per micro-op
    localparam int REG_IDX_W   = 3;  // arch register index width
    localparam int SLOT_DATA_W = 64;

    // where a slot result goes
    typedef enum logic [1:0] {
        DEST_NONE = 2'd0,
        DEST_REG  = 2'd1,
        DEST_SEG  = 2'd2,
        DEST_MEM  = 2'd3
    } dest_kind_e;

    // memory access size codes
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'd0,
        SIZE_WORD  = 2'd1,
        SIZE_DWORD = 2'd2,
        SIZE_QWORD = 2'd3
    } mem_size_e;

    typedef struct packed {
        logic [31-REG_IDX_W:0] rsvd;  // ignored for register targets
        logic [REG_IDX_W-1:0]  idx;
    } wb_reg_view_t;

    // slot destination word, register index or byte address
    typedef union packed {
        wb_reg_view_t rv;
        logic [31:0]  addr;
    } wb_dest_u;

    typedef struct packed {
        logic [SLOT_DATA_W-1:0] data;
        dest_kind_e             kind;
        logic                   wb;     // slot really writes back
        wb_dest_u               dest;
    } wb_slot_t;

    typedef struct packed {
        logic [31:0] eip;       // sequential next eip
        mem_size_e   op_size;
        logic [3:0]  size_ovr;  // one-hot, bit n selects size code n
        logic        far_xfer;
        logic        halt;
        logic        ie;
        logic [2:0]  ie_type;
        logic [15:0] cs;
        logic [17:0] eflags;
    } wb_uop_t;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic        correct;  // prediction was right
        logic [31:0] fip;
    } br_info_t;

    // wbaq entry, also the memory request payload
    typedef struct packed {
        logic [31:0]            addr;
        logic [SLOT_DATA_W-1:0] data;
        mem_size_e              size;
    } mem_wr_t;

    typedef struct packed {
        logic [NUM_SLOTS-1:0]             we;
        logic [NUM_SLOTS*REG_IDX_W-1:0]   idx;
        logic [NUM_SLOTS*SLOT_DATA_W-1:0] data;
    } reg_wr_t;

endpackage

// File: wbaq.sv
`timescale 1ns/1ps

module wbaq #(
    parameter int DEPTH = 4
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            push,
    input  wb_pkg::mem_wr_t push_data,
    input  logic            mem_ack,
    output logic            full,
    output logic            mem_req,
    output wb_pkg::mem_wr_t mem_wr
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef enum logic [1:0] {
        S_IDLE     = 2'd0,
        S_REQ      = 2'd1,
        S_WAIT_LOW = 2'd2  // ack still high from last transfer
    } drain_state_e;

    drain_state_e state;
    drain_state_e state_nxt;

    wb_pkg::mem_wr_t q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    logic             launch;  // head goes out on the port next cycle

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign mem_req = (state == S_REQ);
    assign pop     = (state == S_REQ) && mem_ack;

    always_comb begin
        state_nxt = state;
        launch    = 1'b0;
        case (state)
            S_IDLE: begin
                if (count != '0) begin
                    state_nxt = S_REQ;
                    launch    = 1'b1;
                end
            end
            S_REQ: begin
                if (mem_ack) begin
                    state_nxt = S_WAIT_LOW;
                end
            end
            S_WAIT_LOW: begin
                if (!mem_ack) begin
                    if (count != '0) begin
                        state_nxt = S_REQ;  // back to back drain
                        launch    = 1'b1;
                    end else begin
                        state_nxt = S_IDLE;
                    end
                end
            end
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= S_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            mem_wr <= '0;
        end else begin
            state <= state_nxt;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            if (launch) begin
                mem_wr <= q[rd_ptr];  // held for the whole request
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q[wr_ptr] <= push_data;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |=> !mem_req || $stable(mem_wr))
        else $error("wbaq: mem_wr changed during mem_req");

    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        full |-> !push)
        else $error("wbaq: push while full");

endmodule

// File: writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid_in,
    input  wb_pkg::wb_uop_t  uop,
    input  wb_pkg::wb_slot_t slots [wb_pkg::NUM_SLOTS],
    input  wb_pkg::br_info_t br,
    input  logic             interrupt_in,
    input  logic             full,
    output logic             valid_out,
    output logic             stall,
    output wb_pkg::reg_wr_t  gpr_wr,
    output wb_pkg::reg_wr_t  seg_wr,
    output logic             push,
    output wb_pkg::mem_wr_t  push_data,
    output logic [31:0]      new_eip,
    output logic [31:0]      new_fip_even,
    output logic [31:0]      new_fip_odd,
    output logic             resteer,
    output logic             final_ie_val,
    output logic [3:0]       final_ie_type,
    output logic             halts,
    output logic             halt_flop,
    output logic [15:0]      cs_out,
    output logic [17:0]      eflags_out
);
    localparam int NS  = wb_pkg::NUM_SLOTS;
    localparam int RIW = wb_pkg::REG_IDX_W;
    localparam int SDW = wb_pkg::SLOT_DATA_W;

    logic [NS-1:0]     is_reg;
    logic [NS-1:0]     is_seg;
    logic [NS-1:0]     is_mem;
    logic [SDW-1:0]    slot_data [NS];
    wb_pkg::mem_size_e mem_size;
    logic [31:0]       br_target;
    logic [31:0]       fip_line;
    logic [31:0]       fip_next;

    always_comb begin
        for (int i = 0; i < NS; i++) begin
            is_reg[i]    = slots[i].wb && (slots[i].kind == wb_pkg::DEST_REG);
            is_seg[i]    = slots[i].wb && (slots[i].kind == wb_pkg::DEST_SEG);
            is_mem[i]    = slots[i].wb && (slots[i].kind == wb_pkg::DEST_MEM);
            slot_data[i] = slots[i].data;
        end
        // far transfer: slot 0 carries the new cs selector
        if (uop.far_xfer) begin
            slot_data[0] = {48'h0, slots[0].data[47:32]};
        end
    end

    // only a memory result can be blocked by a full wbaq
    assign stall     = full && valid_in && (|is_mem);
    assign valid_out = valid_in && !stall;

    // load strobes into the register files
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            gpr_wr.we[i]              = valid_out && is_reg[i];
            gpr_wr.idx[i*RIW +: RIW]  = slots[i].dest.rv.idx;
            gpr_wr.data[i*SDW +: SDW] = slot_data[i];
            seg_wr.we[i]              = valid_out && is_seg[i];
            seg_wr.idx[i*RIW +: RIW]  = slots[i].dest.rv.idx;
            seg_wr.data[i*SDW +: SDW] = slot_data[i];
        end
    end

    // override > far transfer > operand size
    always_comb begin
        mem_size = uop.op_size;
        if (uop.size_ovr != 4'h0) begin
            for (int b = 3; b >= 0; b--) begin
                if (uop.size_ovr[b]) begin
                    mem_size = wb_pkg::mem_size_e'(2'(b));
                end
            end
        end else if (uop.far_xfer) begin
            mem_size = wb_pkg::SIZE_QWORD;  // dword offset plus selector
        end
    end

    // lowest numbered memory slot goes to the queue
    always_comb begin
        push_data = '0;
        for (int i = NS - 1; i >= 0; i--) begin
            if (is_mem[i]) begin
                push_data.addr = slots[i].dest.addr;
                push_data.data = slot_data[i];
            end
        end
        push_data.size = mem_size;
    end

    assign push = valid_out && (|is_mem);

    // redirect toward fetch
    assign br_target = uop.far_xfer ? slots[0].data[31:0] : br.fip;
    assign new_eip   = br.taken ? br_target : uop.eip;
    assign fip_line  = {br.fip[31:4], 4'h0};
    assign fip_next  = fip_line + 32'd16;

    assign new_fip_even = br.fip[4] ? fip_next : fip_line;
    assign new_fip_odd  = br.fip[4] ? fip_line : fip_next;
    assign resteer      = valid_out && br.valid && !br.correct;

    assign final_ie_val  = uop.ie || interrupt_in;
    assign final_ie_type = {interrupt_in, uop.ie_type};
    assign halts         = valid_out && uop.halt;

    assign cs_out     = (valid_out && uop.far_xfer) ? slots[0].data[47:32] : uop.cs;
    assign eflags_out = uop.eflags;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halt_flop <= 1'b0;
        end else if (halts) begin
            halt_flop <= 1'b1;  // sticky until reset
        end
    end

    a_one_mem_slot: assert property (@(posedge clk) disable iff (!arst_n)
        valid_in |-> $onehot0(is_mem))
        else $error("writeback_stage: more than one memory slot in a micro-op");

    // upstream keeps a stalled micro-op in place
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
        stall |=> valid_in && $stable(uop))
        else $error("writeback_stage: stalled micro-op not held by upstream");

endmodule

// File: writeback_top.sv
`timescale 1ns/1ps

module writeback_top #(
    parameter int WBAQ_DEPTH = 4,
    parameter int GPR_W      = 32,
    parameter int SEG_W      = 16
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             valid_in,
    input  wb_pkg::wb_uop_t  uop,
    input  wb_pkg::wb_slot_t slots [wb_pkg::NUM_SLOTS],
    input  wb_pkg::br_info_t br,
    input  logic             interrupt_in,
    output logic             valid_out,
    output logic             stall,
    input  logic [2:0]       gpr_rd_idx,
    output logic [GPR_W-1:0] gpr_rd_data,
    input  logic [2:0]       seg_rd_idx,
    output logic [SEG_W-1:0] seg_rd_data,
    output logic             mem_req,
    output wb_pkg::mem_wr_t  mem_wr,
    input  logic             mem_ack,
    output logic [31:0]      new_eip,
    output logic [31:0]      new_fip_even,
    output logic [31:0]      new_fip_odd,
    output logic             resteer,
    output logic             final_ie_val,
    output logic [3:0]       final_ie_type,
    output logic             halts,
    output logic             halt_flop,
    output logic [15:0]      cs_out,
    output logic [17:0]      eflags_out
);
    wb_pkg::reg_wr_t gpr_wr;
    wb_pkg::reg_wr_t seg_wr;
    wb_pkg::mem_wr_t push_data;
    logic            push;
    logic            full;

    writeback_stage stage_i (
        .clk(clk), .arst_n(arst_n), .valid_in(valid_in), .uop(uop), .slots(slots),
        .br(br), .interrupt_in(interrupt_in), .full(full), .valid_out(valid_out),
        .stall(stall), .gpr_wr(gpr_wr), .seg_wr(seg_wr), .push(push),
        .push_data(push_data), .new_eip(new_eip), .new_fip_even(new_fip_even),
        .new_fip_odd(new_fip_odd), .resteer(resteer), .final_ie_val(final_ie_val),
        .final_ie_type(final_ie_type), .halts(halts), .halt_flop(halt_flop),
        .cs_out(cs_out), .eflags_out(eflags_out)
    );

    arch_reg_file #(.DATA_W(GPR_W), .NUM_REGS(8)) gpr_i (  // general registers
        .clk(clk), .arst_n(arst_n), .wr(gpr_wr), .rd_idx(gpr_rd_idx), .rd_data(gpr_rd_data)
    );

    arch_reg_file #(.DATA_W(SEG_W), .NUM_REGS(8)) seg_i (  // segment registers
        .clk(clk), .arst_n(arst_n), .wr(seg_wr), .rd_idx(seg_rd_idx), .rd_data(seg_rd_data)
    );

    wbaq #(.DEPTH(WBAQ_DEPTH)) wbaq_i (
        .clk(clk), .arst_n(arst_n), .push(push), .push_data(push_data),
        .mem_ack(mem_ack), .full(full), .mem_req(mem_req), .mem_wr(mem_wr)
    );

endmodule
